/* Makefile */
# Verilator flow for the VGA controller testbench

VERILATOR  ?= verilator
TOP        ?= vga_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hex_display.sv */
`timescale 1ns/1ns

module hex_display (
	input  logic [15:0]   hex_value,
	output vga_pkg::seg_t hex_seg [4]
);

	// Segment table, bit 6 is g and bit 0 is a, zero lights the segment
	function automatic vga_pkg::seg_t seg_lookup(input logic [3:0] nib);
		case (nib)
			4'h0: seg_lookup = 7'b1000000;
			4'h1: seg_lookup = 7'b1111001;
			4'h2: seg_lookup = 7'b0100100;
			4'h3: seg_lookup = 7'b0110000;
			4'h4: seg_lookup = 7'b0011001;
			4'h5: seg_lookup = 7'b0010010;
			4'h6: seg_lookup = 7'b0000010;
			4'h7: seg_lookup = 7'b1111000;
			4'h8: seg_lookup = 7'b0000000;
			4'h9: seg_lookup = 7'b0010000;
			4'hA: seg_lookup = 7'b0001000;
			// Lower case b and d
			4'hB: seg_lookup = 7'b0000011;
			4'hC: seg_lookup = 7'b1000110;
			4'hD: seg_lookup = 7'b0100001;
			4'hE: seg_lookup = 7'b0000110;
			default: seg_lookup = 7'b0001110;
		endcase
	endfunction

	// Digit 0 takes the lowest nibble
	for (genvar d = 0; d < 4; d++) begin : g_digit
		assign hex_seg[d] = seg_lookup(hex_value[d*4 +: 4]);
	end

endmodule

/* project.f */
vga_pkg.sv
vga_regs.sv
vga_timing.sv
vga_pattern.sv
hex_display.sv
vga_top.sv
vga_checker.sv
tb_clock.sv
vga_tb.sv

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic M10k_pll,
	output logic reset
);

	// 40 ns period
	initial begin
		M10k_pll = 1'b0;
		forever #20 M10k_pll = ~M10k_pll;
	end

	// Three rising edges in reset, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge M10k_pll);
		@(negedge M10k_pll);
		reset = 1'b0;
	end

endmodule

/* vga_checker.sv */
`timescale 1ns/1ns

module vga_checker (
	input logic               M10k_pll,
	input logic               reset,
	input vga_pkg::axil_req_t axil_req,
	input vga_pkg::axil_rsp_t axil_rsp,
	input vga_pkg::vga_out_t  vga_out
);

	// Failure tallies, one per property
	int unsigned blank_fails = 0;
	int unsigned bvalid_fails = 0;
	int unsigned rvalid_fails = 0;
	int unsigned hsync_fails = 0;
	int unsigned fail_count;

	// Length of the current hsync low run
	int unsigned h_low;

	assign fail_count = blank_fails + bvalid_fails + rvalid_fails + hsync_fails;

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_low <= 0;
		end else if (!vga_out.hsync) begin
			h_low <= h_low + 1;
		end else begin
			h_low <= 0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////////////////////////

	// No picture during a sync pulse
	a_blank_in_sync: assert property (@(posedge M10k_pll) disable iff (reset)
		!(vga_out.blank_n && (!vga_out.hsync || !vga_out.vsync)))
	else begin
		$error("blank_n high during a sync pulse");
		blank_fails++;
	end

	// Write response held until taken
	a_bvalid_hold: assert property (@(posedge M10k_pll) disable iff (reset)
		(axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
	else begin
		$error("bvalid dropped without bready");
		bvalid_fails++;
	end

	// Read response held until taken
	a_rvalid_hold: assert property (@(posedge M10k_pll) disable iff (reset)
		(axil_rsp.rvalid && !axil_req.rready) |=> axil_rsp.rvalid)
	else begin
		$error("rvalid dropped without rready");
		rvalid_fails++;
	end

	// Low run just ended
	a_hsync_width: assert property (@(posedge M10k_pll) disable iff (reset)
		$rose(vga_out.hsync) |-> (h_low == 96))
	else begin
		$error("hsync pulse was %0d clocks, not 96", h_low);
		hsync_fails++;
	end

endmodule

bind vga_top vga_checker u_checker (
	.M10k_pll (M10k_pll),
	.reset    (reset),
	.axil_req (axil_req),
	.axil_rsp (axil_rsp),
	.vga_out  (vga_out)
);

/* vga_pattern.sv */
`timescale 1ns/1ns

module vga_pattern (
	input  vga_pkg::disp_cfg_t cfg,
	input  vga_pkg::coord_t    next_x,
	input  vga_pkg::coord_t    next_y,
	input  logic               next_active,
	output vga_pkg::rgb_t      pixel
);

	// Quadrant flags
	logic right;
	logic bottom;

	assign right  = (next_x >= vga_pkg::H_HALF);
	assign bottom = (next_y >= vga_pkg::V_HALF);

	always_comb begin
		pixel = '0;
		if (next_active) begin
			if (cfg.fill_mode) begin
				// Nibble goes to the top of each channel
				pixel.red   = {cfg.fill_color[11:8], 4'h0};
				pixel.green = {cfg.fill_color[7:4], 4'h0};
				pixel.blue  = {cfg.fill_color[3:0], 4'h0};
			end else begin
				case ({bottom, right})
					// Top left, red
					2'b00: pixel.red = vga_pkg::CHAN_MAX;
					// Top right, blue
					2'b01: pixel.blue = vga_pkg::CHAN_MAX;
					// Bottom left, green
					2'b10: pixel.green = vga_pkg::CHAN_MAX;
					// Bottom right yellow
					default: begin
						pixel.red   = vga_pkg::CHAN_MAX;
						pixel.green = vga_pkg::CHAN_MAX;
					end
				endcase
			end
		end
	end

endmodule

/* vga_pkg.sv */
package vga_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////////////////////////

	// Pixel or line coordinate
	typedef logic [9:0]  coord_t;
	// One colour channel
	typedef logic [7:0]  chan_t;
	// 4-4-4 RGB fill colour
	typedef logic [11:0] color12_t;
	// One seven-segment digit, g-f-e-d-c-b-a, active low
	typedef logic [6:0]  seg_t;
	// Register byte address
	typedef logic [3:0]  addr_t;
	// AXI data word
	typedef logic [31:0] word_t;

	//////////////////////////////////////////////////////////////////////
	// Display timing, 640x480 at one pixel per clock
	//////////////////////////////////////////////////////////////////////

	// Horizontal phase lengths in pixel clocks
	localparam coord_t H_ACTIVE = 10'd640;
	localparam coord_t H_FRONT  = 10'd16;
	localparam coord_t H_PULSE  = 10'd96;
	localparam coord_t H_BACK   = 10'd48;

	// Vertical phase lengths in lines
	localparam coord_t V_ACTIVE = 10'd480;
	localparam coord_t V_FRONT  = 10'd10;
	localparam coord_t V_PULSE  = 10'd2;
	localparam coord_t V_BACK   = 10'd33;

	// Quadrant split of the test pattern
	localparam coord_t H_HALF = 10'd320;
	localparam coord_t V_HALF = 10'd240;

	// Full-scale channel
	localparam chan_t CHAN_MAX = 8'hFF;

	// Phases of a line or of a frame, same order for both machines
	typedef enum logic [1:0] {
		PH_ACTIVE,
		PH_FRONT,
		PH_PULSE,
		PH_BACK
	} sync_phase_t;

	//////////////////////////////////////////////////////////////////////
	// Register map and AXI4-Lite
	//////////////////////////////////////////////////////////////////////

	localparam addr_t ADDR_CTRL = 4'h0;
	localparam addr_t ADDR_FILL = 4'h4;
	localparam addr_t ADDR_HEX  = 4'h8;

	localparam logic [1:0] RESP_OKAY   = 2'd0;
	localparam logic [1:0] RESP_SLVERR = 2'd2;

	// Master side of the bus
	typedef struct packed {
		logic  awvalid;
		addr_t awaddr;
		logic  wvalid;
		word_t wdata;
		logic  bready;
		logic  arvalid;
		addr_t araddr;
		logic  rready;
	} axil_req_t;

	// Slave side of the bus
	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		word_t      rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	// Display settings held by the register block
	typedef struct packed {
		logic        fill_mode;
		color12_t    fill_color;
		logic [15:0] hex_value;
	} disp_cfg_t;

	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} rgb_t;

	// Everything that leaves for the DAC and connector
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank_n;
		rgb_t rgb;
	} vga_out_t;

endpackage

/* vga_regs.sv */
`timescale 1ns/1ns

module vga_regs (
	input  logic               M10k_pll,
	input  logic               reset,
	input  vga_pkg::axil_req_t axil_req,
	output vga_pkg::axil_rsp_t axil_rsp,
	output vga_pkg::disp_cfg_t cfg
);

	// Write channel state
	logic           aw_ready_q;
	logic           b_valid_q;
	logic [1:0]     bresp_q;
	logic           wr_fire;
	logic           aw_hit;

	// Read channel state
	logic           ar_ready_q;
	logic           r_valid_q;
	logic [1:0]     rresp_q;
	vga_pkg::word_t rdata_q;
	logic           rd_fire;
	logic           ar_hit;
	vga_pkg::word_t rd_value;

	// Handshakes complete while the ready pulse is up
	assign wr_fire = aw_ready_q && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = ar_ready_q && axil_req.arvalid;

	// Write address decode
	always_comb begin
		case (axil_req.awaddr)
			vga_pkg::ADDR_CTRL,
			vga_pkg::ADDR_FILL,
			vga_pkg::ADDR_HEX: aw_hit = 1'b1;
			default:           aw_hit = 1'b0;
		endcase
	end

	// Read mux, unused bits are zero
	always_comb begin
		rd_value = '0;
		ar_hit   = 1'b1;
		case (axil_req.araddr)
			vga_pkg::ADDR_CTRL: rd_value[0]    = cfg.fill_mode;
			vga_pkg::ADDR_FILL: rd_value[11:0] = cfg.fill_color;
			vga_pkg::ADDR_HEX:  rd_value[15:0] = cfg.hex_value;
			default:            ar_hit         = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Write path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			aw_ready_q <= 1'b0;
			b_valid_q  <= 1'b0;
			cfg        <= '0;
		end else begin
			// One-cycle ready, never while a response waits
			aw_ready_q <= axil_req.awvalid && axil_req.wvalid && !aw_ready_q && !b_valid_q;
			if (wr_fire) begin
				b_valid_q <= 1'b1;
			end else if (axil_req.bready) begin
				b_valid_q <= 1'b0;
			end
			// Field update on the handshake edge
			if (wr_fire) begin
				case (axil_req.awaddr)
					vga_pkg::ADDR_CTRL: cfg.fill_mode  <= axil_req.wdata[0];
					vga_pkg::ADDR_FILL: cfg.fill_color <= axil_req.wdata[11:0];
					vga_pkg::ADDR_HEX:  cfg.hex_value  <= axil_req.wdata[15:0];
					default: ;
				endcase
			end
		end
	end

	// Write response code
	always_ff @(posedge M10k_pll) begin
		if (wr_fire) begin
			bresp_q <= aw_hit ? vga_pkg::RESP_OKAY : vga_pkg::RESP_SLVERR;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			ar_ready_q <= 1'b0;
			r_valid_q  <= 1'b0;
		end else begin
			ar_ready_q <= axil_req.arvalid && !ar_ready_q && !r_valid_q;
			if (rd_fire) begin
				r_valid_q <= 1'b1;
			end else if (axil_req.rready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	// Data and code captured with the address
	always_ff @(posedge M10k_pll) begin
		if (rd_fire) begin
			rdata_q <= rd_value;
			rresp_q <= ar_hit ? vga_pkg::RESP_OKAY : vga_pkg::RESP_SLVERR;
		end
	end

	// Slave outputs
	always_comb begin
		axil_rsp.awready = aw_ready_q;
		axil_rsp.wready  = aw_ready_q;
		axil_rsp.bvalid  = b_valid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = ar_ready_q;
		axil_rsp.rvalid  = r_valid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
	end

endmodule

/* vga_tb.sv */
`timescale 1ns/1ns

module vga_tb;

	logic               M10k_pll;
	logic               reset;
	vga_pkg::axil_req_t axil_req;
	vga_pkg::axil_rsp_t axil_rsp;
	vga_pkg::vga_out_t  vga_out;
	vga_pkg::seg_t      hex_seg [4];

	int unsigned value_errors;
	int unsigned timeout_errors;
	// Expected register contents
	vga_pkg::word_t shadow_ctrl;
	vga_pkg::word_t shadow_fill;
	vga_pkg::word_t shadow_hex;
	// Digits seen one clock after the last write handshake
	vga_pkg::seg_t  seg_after_wr [4];

	tb_clock u_clock (
		.M10k_pll (M10k_pll),
		.reset    (reset)
	);

	vga_top UUT (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.vga_out  (vga_out),
		.hex_seg  (hex_seg)
	);

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and reference models
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string what, input vga_pkg::word_t got,
			input vga_pkg::word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: response %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_rgb(input string what, input vga_pkg::rgb_t got,
			input vga_pkg::rgb_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: colour %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_seg(input string what, input vga_pkg::seg_t got,
			input vga_pkg::seg_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: segments %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Lit segments as g-f-e-d-c-b-a and inverted for the active-low digit
	function automatic vga_pkg::seg_t seg_expect(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		seg_expect = ~lit;
	endfunction

	// Quadrant rule of the test picture
	function automatic vga_pkg::rgb_t quadrant_color(input int unsigned x, input int unsigned y);
		if (y < 240) begin
			quadrant_color = (x < 320) ? 24'hFF0000 : 24'h0000FF;
		end else begin
			quadrant_color = (x < 320) ? 24'h00FF00 : 24'hFFFF00;
		end
	endfunction

	// Sample columns and rows on both sides of each split
	function automatic logic is_sample(input int unsigned x, input int unsigned y);
		logic col;
		logic row;
		col = (x == 0) || (x == 100) || (x == 319) || (x == 320) || (x == 639);
		row = (y == 0) || (y == 120) || (y == 239) || (y == 240) || (y == 479);
		is_sample = col && row;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite master
	//////////////////////////////////////////////////////////////////////

	task automatic axil_write(input vga_pkg::addr_t addr, input vga_pkg::word_t data,
			input int unsigned hold, output logic [1:0] resp);
		int unsigned n;
		resp = 2'b11;
		@(negedge M10k_pll);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.bready  = 1'b0;
		n = 0;
		@(negedge M10k_pll);
		while (!axil_rsp.awready && !axil_rsp.wready && n < 16) begin
			@(negedge M10k_pll);
			n++;
		end
		if (!axil_rsp.awready && !axil_rsp.wready) begin
			timeout_errors++;
			$display("Timeout: write to address %h was never accepted", addr);
			axil_req.awvalid = 1'b0;
			axil_req.wvalid  = 1'b0;
			return;
		end
		// Address and data are taken on the same edge
		if (axil_rsp.awready !== axil_rsp.wready) begin
			value_errors++;
			$display("[ERROR] %0t write %h: awready %b and wready %b differ", $time, addr,
				axil_rsp.awready, axil_rsp.wready);
		end
		// Handshake lands on the next rising edge
		@(negedge M10k_pll);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		seg_after_wr = hex_seg;
		n = 0;
		while (!axil_rsp.bvalid && n < 16) begin
			@(negedge M10k_pll);
			n++;
		end
		if (!axil_rsp.bvalid) begin
			timeout_errors++;
			$display("Timeout: no write response for address %h", addr);
			return;
		end
		resp = axil_rsp.bresp;
		// Back-pressure on the response
		repeat (hold) @(negedge M10k_pll);
		axil_req.bready = 1'b1;
		@(negedge M10k_pll);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input vga_pkg::addr_t addr, input int unsigned hold,
			output vga_pkg::word_t data, output logic [1:0] resp);
		int unsigned n;
		data = '0;
		resp = 2'b11;
		@(negedge M10k_pll);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		axil_req.rready  = 1'b0;
		n = 0;
		@(negedge M10k_pll);
		while (!axil_rsp.arready && n < 16) begin
			@(negedge M10k_pll);
			n++;
		end
		if (!axil_rsp.arready) begin
			timeout_errors++;
			$display("Timeout: read of address %h was never accepted", addr);
			axil_req.arvalid = 1'b0;
			return;
		end
		@(negedge M10k_pll);
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_rsp.rvalid && n < 16) begin
			@(negedge M10k_pll);
			n++;
		end
		if (!axil_rsp.rvalid) begin
			timeout_errors++;
			$display("Timeout: no read data for address %h", addr);
			return;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		repeat (hold) @(negedge M10k_pll);
		axil_req.rready = 1'b1;
		@(negedge M10k_pll);
		axil_req.rready = 1'b0;
	endtask

	// Mapped write with expected contents masked to the field
	task automatic write_reg(input vga_pkg::addr_t addr, input vga_pkg::word_t data);
		logic [1:0] resp;
		axil_write(addr, data, $urandom_range(0, 6), resp);
		check_resp($sformatf("write %h", addr), resp, vga_pkg::RESP_OKAY);
		case (addr)
			vga_pkg::ADDR_CTRL: shadow_ctrl = data & 32'h0000_0001;
			vga_pkg::ADDR_FILL: shadow_fill = data & 32'h0000_0FFF;
			default:            shadow_hex  = data & 32'h0000_FFFF;
		endcase
	endtask

	task automatic verify_regs();
		vga_pkg::word_t data;
		logic [1:0]     resp;
		axil_read(vga_pkg::ADDR_CTRL, $urandom_range(0, 6), data, resp);
		check_resp("read ctrl", resp, vga_pkg::RESP_OKAY);
		check_word("read ctrl", data, shadow_ctrl);
		axil_read(vga_pkg::ADDR_FILL, $urandom_range(0, 6), data, resp);
		check_resp("read fill", resp, vga_pkg::RESP_OKAY);
		check_word("read fill", data, shadow_fill);
		axil_read(vga_pkg::ADDR_HEX, $urandom_range(0, 6), data, resp);
		check_resp("read hex", resp, vga_pkg::RESP_OKAY);
		check_word("read hex", data, shadow_hex);
	endtask

	// Returns on the first clock of a vsync pulse
	task automatic wait_vsync_fall(output logic found);
		logic        prev;
		int unsigned n;
		found = 1'b0;
		prev  = vga_out.vsync;
		for (n = 0; n < 430000 && !found; n++) begin
			@(negedge M10k_pll);
			found = prev && !vga_out.vsync;
			prev  = vga_out.vsync;
		end
		if (!found) begin
			timeout_errors++;
			$display("Timeout: no vsync pulse seen within a frame");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_registers();
		int unsigned i;
		for (i = 0; i < 4; i++) begin
			write_reg(vga_pkg::ADDR_CTRL, $urandom);
			write_reg(vga_pkg::ADDR_FILL, $urandom);
			write_reg(vga_pkg::ADDR_HEX, $urandom);
			verify_regs();
		end
	endtask

	task automatic test_unmapped();
		vga_pkg::word_t data;
		logic [1:0]     resp;
		axil_write(4'hC, $urandom, 2, resp);
		check_resp("write 0xC", resp, vga_pkg::RESP_SLVERR);
		axil_read(4'hC, 3, data, resp);
		check_resp("read 0xC", resp, vga_pkg::RESP_SLVERR);
		check_word("read 0xC", data, 32'h0);
		// Nothing else may have moved
		verify_regs();
	endtask

	task automatic test_hex();
		vga_pkg::word_t val;
		int unsigned    i;
		int unsigned    d;
		for (i = 0; i < 4; i++) begin
			val = $urandom;
			write_reg(vga_pkg::ADDR_HEX, val);
			for (d = 0; d < 4; d++) begin
				check_seg($sformatf("digit %0d", d), seg_after_wr[d],
					seg_expect(val[d*4 +: 4]));
			end
		end
	endtask

	// One frame from vsync fall to vsync fall
	task automatic test_timing();
		logic        found;
		logic        done;
		logic        ph;
		logic        pb;
		logic        pv;
		logic        have_hfall;
		int unsigned clocks;
		int unsigned last_hfall;
		int unsigned vlow;
		int unsigned run;
		int unsigned lines;
		wait_vsync_fall(found);
		if (!found) begin
			return;
		end
		done = 1'b0;
		have_hfall = 1'b0;
		clocks = 0;
		last_hfall = 0;
		vlow = 1;
		run = 0;
		lines = 0;
		ph = vga_out.hsync;
		pb = vga_out.blank_n;
		pv = vga_out.vsync;
		while (!done && clocks < 430000) begin
			@(negedge M10k_pll);
			clocks++;
			if (pv && !vga_out.vsync) begin
				done = 1'b1;
			end else begin
				if (!vga_out.vsync) begin
					vlow++;
				end
				if (ph && !vga_out.hsync) begin
					if (have_hfall) begin
						check_word("hsync period", clocks - last_hfall, 32'd800);
					end
					have_hfall = 1'b1;
					last_hfall = clocks;
				end
				if (vga_out.blank_n) begin
					run++;
				end else if (pb) begin
					check_word("active line length", run, 32'd640);
					lines++;
					run = 0;
				end
			end
			ph = vga_out.hsync;
			pb = vga_out.blank_n;
			pv = vga_out.vsync;
		end
		if (!done) begin
			timeout_errors++;
			$display("Timeout: the frame did not end with a second vsync pulse");
		end
		check_word("frame length", clocks, 32'd420000);
		check_word("active lines", lines, 32'd480);
		check_word("vsync low clocks", vlow, 32'd1600);
	endtask

	// Walks one frame with x and y counted from blank_n on the pins
	task automatic scan_frame(input logic fill, input vga_pkg::rgb_t fill_rgb);
		logic        found;
		logic        pb;
		int unsigned n;
		int unsigned x;
		int unsigned y;
		int unsigned samples;
		wait_vsync_fall(found);
		if (!found) begin
			return;
		end
		x = 0;
		y = 0;
		samples = 0;
		pb = vga_out.blank_n;
		for (n = 0; n < 420000; n++) begin
			@(negedge M10k_pll);
			if (vga_out.blank_n) begin
				if (fill && (x % 40 == 0) && (y % 40 == 0)) begin
					check_rgb($sformatf("fill %0d,%0d", x, y), vga_out.rgb, fill_rgb);
					samples++;
				end else if (!fill && is_sample(x, y)) begin
					check_rgb($sformatf("pattern %0d,%0d", x, y), vga_out.rgb,
						quadrant_color(x, y));
					samples++;
				end
				x++;
			end else begin
				check_rgb("blanked colour", vga_out.rgb, 24'h0);
				if (pb) begin
					y++;
					x = 0;
				end
			end
			pb = vga_out.blank_n;
		end
		check_word("samples taken", samples, fill ? 32'd192 : 32'd25);
	endtask

	task automatic test_pattern();
		write_reg(vga_pkg::ADDR_CTRL, 32'h0);
		scan_frame(1'b0, 24'h0);
	endtask

	task automatic test_fill();
		vga_pkg::word_t   val;
		vga_pkg::color12_t color;
		vga_pkg::rgb_t    exp_rgb;
		val = $urandom;
		color = val[11:0];
		// Each nibble becomes the top of its channel
		exp_rgb = {color[11:8], 4'h0, color[7:4], 4'h0, color[3:0], 4'h0};
		write_reg(vga_pkg::ADDR_FILL, val);
		write_reg(vga_pkg::ADDR_CTRL, 32'h1);
		scan_frame(1'b1, exp_rgb);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int unsigned n;
		int unsigned total;
		axil_req = '0;
		value_errors = 0;
		timeout_errors = 0;
		shadow_ctrl = '0;
		shadow_fill = '0;
		shadow_hex = '0;
		void'($urandom(32'h32fef511));
		n = 0;
		@(negedge M10k_pll);
		while (reset && n < 10) begin
			@(negedge M10k_pll);
			n++;
		end
		if (reset) begin
			timeout_errors++;
			$display("Timeout: reset was never released");
		end else begin
			// Reset values first
			verify_regs();
			test_registers();
			test_unmapped();
			test_hex();
			test_timing();
			test_pattern();
			test_fill();
		end
		total = value_errors + timeout_errors + UUT.u_checker.fail_count;
		$display("Errors: %0d value, %0d timeout, %0d assertion", value_errors, timeout_errors,
			UUT.u_checker.fail_count);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* vga_timing.sv */
`timescale 1ns/1ns

module vga_timing (
	input  logic              M10k_pll,
	input  logic              reset,
	input  vga_pkg::rgb_t     pixel,
	output vga_pkg::coord_t   next_x,
	output vga_pkg::coord_t   next_y,
	output logic              next_active,
	output vga_pkg::vga_out_t vga_out
);

	vga_pkg::sync_phase_t h_state;
	vga_pkg::sync_phase_t v_state;
	vga_pkg::coord_t      h_count;
	vga_pkg::coord_t      v_count;
	logic                 line_done;
	logic                 active_now;

	// Phase order is the same for lines and frames
	function automatic vga_pkg::sync_phase_t phase_after(input vga_pkg::sync_phase_t ph);
		case (ph)
			vga_pkg::PH_ACTIVE: phase_after = vga_pkg::PH_FRONT;
			vga_pkg::PH_FRONT:  phase_after = vga_pkg::PH_PULSE;
			vga_pkg::PH_PULSE:  phase_after = vga_pkg::PH_BACK;
			default:            phase_after = vga_pkg::PH_ACTIVE;
		endcase
	endfunction

	// Last count of a horizontal phase
	function automatic vga_pkg::coord_t h_last(input vga_pkg::sync_phase_t ph);
		case (ph)
			vga_pkg::PH_ACTIVE: h_last = vga_pkg::H_ACTIVE - 10'd1;
			vga_pkg::PH_FRONT:  h_last = vga_pkg::H_FRONT - 10'd1;
			vga_pkg::PH_PULSE:  h_last = vga_pkg::H_PULSE - 10'd1;
			default:            h_last = vga_pkg::H_BACK - 10'd1;
		endcase
	endfunction

	// Last count of a vertical phase
	function automatic vga_pkg::coord_t v_last(input vga_pkg::sync_phase_t ph);
		case (ph)
			vga_pkg::PH_ACTIVE: v_last = vga_pkg::V_ACTIVE - 10'd1;
			vga_pkg::PH_FRONT:  v_last = vga_pkg::V_FRONT - 10'd1;
			vga_pkg::PH_PULSE:  v_last = vga_pkg::V_PULSE - 10'd1;
			default:            v_last = vga_pkg::V_BACK - 10'd1;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Horizontal machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_state   <= vga_pkg::PH_ACTIVE;
			h_count   <= '0;
			line_done <= 1'b0;
		end else begin
			if (h_count == h_last(h_state)) begin
				h_count <= '0;
				h_state <= phase_after(h_state);
			end else begin
				h_count <= h_count + 10'd1;
			end
			// Early by one so it lines up with the wrap to active
			line_done <= (h_state == vga_pkg::PH_BACK) && (h_count == vga_pkg::H_BACK - 10'd2);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Vertical machine, steps once per line
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			v_state <= vga_pkg::PH_ACTIVE;
			v_count <= '0;
		end else if (line_done) begin
			if (v_count == v_last(v_state)) begin
				v_count <= '0;
				v_state <= phase_after(v_state);
			end else begin
				v_count <= v_count + 10'd1;
			end
		end
	end

	// Visible region from the current phases
	assign active_now = (h_state == vga_pkg::PH_ACTIVE) && (v_state == vga_pkg::PH_ACTIVE);

	// Coordinate whose colour shows on the next clock
	assign next_x      = (h_state == vga_pkg::PH_ACTIVE) ? h_count : '0;
	assign next_y      = (v_state == vga_pkg::PH_ACTIVE) ? v_count : '0;
	assign next_active = active_now;

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			vga_out.hsync   <= 1'b1;
			vga_out.vsync   <= 1'b1;
			vga_out.blank_n <= 1'b0;
			vga_out.rgb     <= '0;
		end else begin
			// Sync pulses are active low
			vga_out.hsync   <= (h_state != vga_pkg::PH_PULSE);
			vga_out.vsync   <= (v_state != vga_pkg::PH_PULSE);
			vga_out.blank_n <= active_now;
			// Black outside the picture
			vga_out.rgb     <= active_now ? pixel : '0;
		end
	end

endmodule

/* vga_top.sv */
`timescale 1ns/1ns

module vga_top (
	input  logic               M10k_pll,
	input  logic               reset,
	input  vga_pkg::axil_req_t axil_req,
	output vga_pkg::axil_rsp_t axil_rsp,
	output vga_pkg::vga_out_t  vga_out,
	output vga_pkg::seg_t      hex_seg [4]
);

	// Settings from the register block
	vga_pkg::disp_cfg_t cfg;

	// Scan position and the colour chosen for it
	vga_pkg::coord_t next_x;
	vga_pkg::coord_t next_y;
	logic            next_active;
	vga_pkg::rgb_t   pixel;

	// Bus slave and settings
	vga_regs u_regs (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.cfg      (cfg)
	);

	// Sync generation and output register
	vga_timing u_timing (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.pixel       (pixel),
		.next_x      (next_x),
		.next_y      (next_y),
		.next_active (next_active),
		.vga_out     (vga_out)
	);

	// Picture source
	vga_pattern u_pattern (
		.cfg         (cfg),
		.next_x      (next_x),
		.next_y      (next_y),
		.next_active (next_active),
		.pixel       (pixel)
	);

	// Four digits of the hex register
	hex_display u_hex (
		.hex_value (cfg.hex_value),
		.hex_seg   (hex_seg)
	);

endmodule
